// File: src/gb_cart_macros.svh
// ------------------------------------------------
// constants shared by the cartridge blocks
// header byte offsets, mapper register windows,
// the ram enable key and the backup sector shape
// ------------------------------------------------

`ifndef GB_CART_MACROS_SVH
`define GB_CART_MACROS_SVH

// download byte addresses of the header words
`define HDR_CGB_WADDR      25'h142 // cgb flag in high byte
`define HDR_TYPE_WADDR     25'h146 // cartridge type in high byte
`define HDR_SIZE_WADDR     25'h148 // {ram size, rom size}

`define RAM_ENABLE_KEY     4'hA    // low nibble that opens cart ram

`define SECTOR_WORDS_BITS  8       // 256 words of 16 bits per sector
`define CRAM_WORD_BITS     16      // word index width of cart ram

// cart_addr[15:13] windows
`define WIN_RAMEN          3'd0    // 0000-1fff
`define WIN_ROMBANK        3'd1    // 2000-3fff
`define WIN_RAMBANK        3'd2    // 4000-5fff
`define WIN_MODE           3'd3    // 6000-7fff
`define WIN_CRAM           3'd5    // a000-bfff

`endif

// File: src/gb_cart_pkg.sv
// ------------------------------------------------
// types for the cartridge subsystem
// imported by every block that names a typed port
// ------------------------------------------------

package gb_cart_pkg;

	typedef logic [7:0]  byte_t;      // cpu data byte
	typedef logic [15:0] word_t;      // rom or sd data word
	typedef logic [15:0] cart_addr_t; // cpu cartridge address
	typedef logic [8:0]  rom_bank_t;  // up to 512 banks (mbc5)
	typedef logic [3:0]  ram_bank_t;  // up to 16 ram banks
	typedef logic [23:0] rom_waddr_t; // rom word address
	typedef logic [16:0] cram_addr_t; // cart ram byte address, 128 KB
	typedef logic [7:0]  lba_t;       // backup sector index

	// mapper families that are decoded from the type byte
	typedef enum logic [2:0] {
		MBC_NONE,
		MBC_1,
		MBC_2,
		MBC_3,
		MBC_5
	} mbc_kind_t;

	// backup sequencer
	typedef enum logic {
		BK_IDLE,
		BK_XFER
	} bk_state_t;

endpackage

// File: src/cart_header.sv
// ------------------------------------------------
// cartridge header capture
// snoops the rom download for the header words and
// decodes mapper kind, battery and bank masks
// ------------------------------------------------
`timescale 1ns/10ps
`include "gb_cart_macros.svh"

module cart_header (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_wr,       // one strobe per downloaded word
	input  logic [24:0]            dl_addr,     // byte address
	input  gb_cart_pkg::word_t     dl_data,
	output gb_cart_pkg::mbc_kind_t cart_kind,
	output logic                   cgb_game,
	output logic                   has_battery,
	output gb_cart_pkg::rom_bank_t rom_mask,
	output gb_cart_pkg::ram_bank_t ram_mask,
	output gb_cart_pkg::lba_t      file_mask,   // last sector of the save file
	output logic                   ram_present
);
	import gb_cart_pkg::*;

	byte_t cgb_flag;
	byte_t mbc_type;
	byte_t rom_size;
	byte_t ram_size;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cgb_flag <= '0;
			mbc_type <= '0;
			rom_size <= '0;
			ram_size <= '0;
		end else if (dl_wr) begin
			if (dl_addr == `HDR_CGB_WADDR) cgb_flag <= dl_data[15:8];
			if (dl_addr == `HDR_TYPE_WADDR) mbc_type <= dl_data[15:8];
			if (dl_addr == `HDR_SIZE_WADDR) {ram_size, rom_size} <= dl_data;
		end
	end

	// ------------------------------------------------
	// type byte decode
	always_comb begin
		unique case (mbc_type)
			8'h01, 8'h02, 8'h03:                      cart_kind = MBC_1;
			8'h05, 8'h06:                             cart_kind = MBC_2;
			8'h0F, 8'h10, 8'h11, 8'h12, 8'h13:        cart_kind = MBC_3;
			8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1E: cart_kind = MBC_5;
			default:                                  cart_kind = MBC_NONE; // rom only
		endcase
	end

	assign has_battery = mbc_type inside {8'h03, 8'h06, 8'h09, 8'h0D, 8'h10,
	                                      8'h13, 8'h1B, 8'h1E, 8'h22, 8'hFF};
	assign cgb_game    = (cgb_flag == 8'h80) || (cgb_flag == 8'hC0);
	assign ram_present = (ram_size != 8'h00) || (cart_kind == MBC_2); // mbc2 has ram on chip

	// size codes to mirroring masks
	always_comb begin
		if (rom_size <= 8'd8)
			rom_mask = rom_bank_t'((10'd2 << rom_size[3:0]) - 10'd1); // 2^(n+1) banks
		else
			rom_mask = 9'h07F;     // odd sizes 0x52..0x54 fold into 128 banks

		unique case (ram_size)
			8'h00, 8'h01, 8'h02: ram_mask = 4'h0; // single bank
			8'h03:               ram_mask = 4'h3; // 32 KB
			default:             ram_mask = 4'hF; // 128 KB
		endcase

		if (cart_kind == MBC_2)   file_mask = 8'h01; // 512 x 4 bits
		else if (ram_size == 1)   file_mask = 8'h03;
		else if (ram_size == 2)   file_mask = 8'h0F;
		else if (ram_size == 3)   file_mask = 8'h3F;
		else                      file_mask = 8'hFF;
	end

endmodule

// File: src/mbc_regs.sv
// ------------------------------------------------
// mapper registers written by the cpu
// rom bank, ram bank, mbc1 mode, mbc3 rtc select
// and ram enable, one shared set for all mappers
// ------------------------------------------------
`timescale 1ns/10ps
`include "gb_cart_macros.svh"

module mbc_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cart_ce,    // cpu double rate enable
	input  logic                   cart_wr,
	input  gb_cart_pkg::cart_addr_t cart_addr,
	input  gb_cart_pkg::byte_t     cart_di,
	input  gb_cart_pkg::mbc_kind_t cart_kind,
	output gb_cart_pkg::rom_bank_t rom_bank,
	output gb_cart_pkg::ram_bank_t ram_bank,
	output logic                   mbc1_mode,  // 0: 16/8 mode, 1: 4/32 mode
	output logic                   rtc_mode,   // mbc3 rtc mapped at a000
	output logic                   ram_enable
);
	import gb_cart_pkg::*;

	logic reg_wr;

	assign reg_wr = cart_ce && cart_wr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank   <= 9'd1;
			ram_bank   <= '0;
			mbc1_mode  <= 1'b0;
			rtc_mode   <= 1'b0;
			ram_enable <= 1'b0;
		end else if (reg_wr) begin
			case (cart_addr[15:13])
				`WIN_RAMEN: begin
					ram_enable <= (cart_di[3:0] == `RAM_ENABLE_KEY);
				end

				`WIN_ROMBANK: begin
					if (cart_kind == MBC_5) begin
						if (cart_addr[12])
							rom_bank[8] <= cart_di[0];   // 3000-3fff
						else
							rom_bank[7:0] <= cart_di;    // 2000-2fff, bank 0 allowed
					end else if (cart_di[6:0] == 7'd0) begin
						rom_bank <= 9'd1;                // mbc1-3 never select bank 0
					end else begin
						rom_bank <= {2'b00, cart_di[6:0]};
					end
				end

				`WIN_RAMBANK: begin
					if (cart_kind == MBC_3) begin
						rtc_mode <= cart_di[3];          // 08-0c pick an rtc register
						if (!cart_di[3])
							ram_bank <= {2'b00, cart_di[1:0]};
					end else if (cart_kind == MBC_5) begin
						ram_bank <= cart_di[3:0];
					end else begin
						ram_bank <= {2'b00, cart_di[1:0]};
					end
				end

				`WIN_MODE: begin
					if (cart_kind == MBC_1)
						mbc1_mode <= cart_di[0];
				end

				default: ; // rom area above 8000 and cart ram carry no registers
			endcase
		end
	end

endmodule

// File: src/cart_map.sv
// ------------------------------------------------
// cpu address mapping
// turns cart_addr into the rom word address and the
// cart ram byte address, and muxes read data back
// ------------------------------------------------
`timescale 1ns/10ps
`include "gb_cart_macros.svh"

module cart_map (
	input  gb_cart_pkg::cart_addr_t cart_addr,
	input  logic                   cart_rd,
	input  logic                   cart_wr,
	input  logic                   cart_ce,
	input  gb_cart_pkg::mbc_kind_t cart_kind,
	input  gb_cart_pkg::rom_bank_t rom_bank,
	input  gb_cart_pkg::ram_bank_t ram_bank,
	input  logic                   mbc1_mode,
	input  logic                   rtc_mode,
	input  logic                   ram_enable,
	input  gb_cart_pkg::rom_bank_t rom_mask,
	input  gb_cart_pkg::ram_bank_t ram_mask,
	input  gb_cart_pkg::word_t     rom_data,
	input  gb_cart_pkg::byte_t     cram_q,     // registered ram read
	output gb_cart_pkg::rom_waddr_t rom_addr,
	output logic                   rom_oe,
	output gb_cart_pkg::cram_addr_t cram_addr,
	output logic                   cram_we,
	output gb_cart_pkg::byte_t     cart_do
);
	import gb_cart_pkg::*;

	logic      in_cram;
	rom_bank_t hi_bank;   // masked bank for 4000-7fff
	rom_bank_t bank_sel;
	ram_bank_t cram_bank;
	byte_t     cram_do;

	assign in_cram = (cart_addr[15:13] == `WIN_CRAM);

	// ------------------------------------------------
	// rom banking
	always_comb begin
		unique case (cart_kind)
			MBC_1:        hi_bank = {2'b00, (mbc1_mode ? 2'b00 : ram_bank[1:0]),
			                         rom_bank[4:0]} & rom_mask; // ram bits as 6..5 in mode 0
			MBC_2, MBC_3: hi_bank = {2'b00, rom_bank[6:0]} & rom_mask;
			MBC_5:        hi_bank = rom_bank & rom_mask;
			default:      hi_bank = '0;
		endcase

		if (cart_kind == MBC_NONE)
			bank_sel = {8'd0, cart_addr[14]};  // 32 KB linear
		else if (cart_addr[15:14] == 2'b01)
			bank_sel = hi_bank;
		else
			bank_sel = '0;                     // 0000-3fff is always bank 0
	end

	assign rom_addr = {2'b00, bank_sel, cart_addr[13:1]}; // 8K words per bank
	assign rom_oe   = cart_rd && !in_cram;

	// ------------------------------------------------
	// ram banking, mbc2 and rom-only carts see bank 0
	always_comb begin
		unique case (cart_kind)
			MBC_1:   cram_bank = {2'b00, (mbc1_mode ? ram_bank[1:0] : 2'b00) & ram_mask[1:0]};
			MBC_3:   cram_bank = {2'b00, ram_bank[1:0] & ram_mask[1:0]};
			MBC_5:   cram_bank = ram_bank & ram_mask;
			default: cram_bank = '0;
		endcase
	end

	assign cram_addr = {cram_bank, cart_addr[12:0]};
	assign cram_we   = cart_wr && cart_ce && in_cram;

	// read data rules per mapper
	always_comb begin
		if (!ram_enable)
			cram_do = 8'hFF;                           // ram closed
		else if (cart_kind == MBC_2 && cart_addr[15:9] == 7'b1010000)
			cram_do = {4'hF, cram_q[3:0]};             // 4-bit ram, open upper nibble
		else if (rtc_mode)
			cram_do = 8'h00;                           // no rtc model
		else
			cram_do = cram_q;
	end

	assign cart_do = in_cram ? cram_do :
	                 cart_addr[0] ? rom_data[15:8] : rom_data[7:0];

endmodule

// File: src/cart_ram.sv
// ------------------------------------------------
// battery backed cart ram, 128 KB
// two byte lanes of 64K entries; the cpu port
// moves bytes, the backup port moves whole words
// ------------------------------------------------
`timescale 1ns/10ps
`include "gb_cart_macros.svh"

module cart_ram (
	input  logic                    clk_sys,
	input  gb_cart_pkg::cram_addr_t cram_addr,  // byte address, bit 0 picks the lane
	input  logic                    cram_we,
	input  gb_cart_pkg::byte_t      cart_di,
	output gb_cart_pkg::byte_t      cram_q,
	input  logic [16:0]             bk_addr,    // word address from the sequencer
	input  logic                    bk_we,
	input  gb_cart_pkg::word_t      bk_din,
	output gb_cart_pkg::word_t      bk_q
);
	import gb_cart_pkg::*;

	byte_t cpu_lane_q [2];
	byte_t bk_lane_q  [2];
	logic  lane_sel;       // lane of the pending cpu read

	for (genvar lane = 0; lane < 2; lane++) begin : g_lane
		byte_t mem [0:(1 << `CRAM_WORD_BITS) - 1];

		// cpu port
		always @(posedge clk_sys) begin
			if (cram_we && cram_addr[0] == lane[0])
				mem[cram_addr[16:1]] <= cart_di;
			cpu_lane_q[lane] <= mem[cram_addr[16:1]];
		end

		// backup port
		always @(posedge clk_sys) begin
			if (bk_we)
				mem[bk_addr[`CRAM_WORD_BITS-1:0]] <= bk_din[lane*8 +: 8];
			bk_lane_q[lane] <= mem[bk_addr[`CRAM_WORD_BITS-1:0]];
		end
	end

	always_ff @(posedge clk_sys)
		lane_sel <= cram_addr[0];

	assign cram_q = lane_sel ? cpu_lane_q[1] : cpu_lane_q[0];
	assign bk_q   = {bk_lane_q[1], bk_lane_q[0]};

endmodule

// File: src/backup_ctrl.sv
// ------------------------------------------------
// backup ram save / load sequencer
// a request edge starts at sector 0; each sd_ack
// fall ends a sector until file_mask is reached
// ------------------------------------------------
`timescale 1ns/10ps
`include "gb_cart_macros.svh"

module backup_ctrl (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          load_req,
	input  logic                          save_req,
	input  logic                          has_battery,
	input  logic                          ram_present,
	input  gb_cart_pkg::lba_t             file_mask,
	input  logic                          sd_ack,
	input  logic [`SECTOR_WORDS_BITS-1:0] sd_buff_addr,
	input  logic                          sd_buff_wr,
	output gb_cart_pkg::lba_t             sd_lba,
	output logic                          sd_rd,
	output logic                          sd_wr,
	output gb_cart_pkg::cram_addr_t       bk_addr,   // word address into cart ram
	output logic                          bk_we,
	output logic                          busy
);
	import gb_cart_pkg::*;

	bk_state_t bk_state;
	logic      loading;       // direction of the running transfer
	logic      old_load, old_save, old_ack;
	logic      load_rise, save_rise;

	assign load_rise = load_req && !old_load;
	assign save_rise = save_req && !old_save;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_state <= BK_IDLE;
			loading  <= 1'b0;
			sd_lba   <= '0;
			sd_rd    <= 1'b0;
			sd_wr    <= 1'b0;
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
		end else begin
			old_load <= load_req;
			old_save <= save_req;
			old_ack  <= sd_ack;

			if (sd_ack && !old_ack) begin
				sd_rd <= 1'b0;        // host took the request
				sd_wr <= 1'b0;
			end

			if (bk_state == BK_IDLE) begin
				if (has_battery && ram_present && (load_rise || save_rise)) begin
					bk_state <= BK_XFER;
					loading  <= load_rise;  // load wins a tie
					sd_lba   <= '0;
					sd_rd    <= load_rise;
					sd_wr    <= !load_rise;
				end
			end else if (old_ack && !sd_ack) begin   // sector done
				if (sd_lba >= file_mask) begin
					bk_state <= BK_IDLE;
					loading  <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 8'd1;
					sd_rd  <= loading;
					sd_wr  <= !loading;
				end
			end
		end
	end

	assign bk_addr = {1'b0, sd_lba, sd_buff_addr};
	assign bk_we   = sd_buff_wr && sd_ack;
	assign busy    = (bk_state != BK_IDLE);

endmodule

// File: src/gb_cart_top.sv
// ------------------------------------------------
// game boy cartridge subsystem top level
// header capture, mapper registers, address map,
// cart ram and the sd backup sequencer
// ------------------------------------------------
`timescale 1ns/10ps
`include "gb_cart_macros.svh"

module gb_cart_top (
	input  logic                          clk_sys,
	input  logic                          reset,
	// rom image download
	input  logic                          dl_wr,
	input  logic [24:0]                   dl_addr,
	input  gb_cart_pkg::word_t            dl_data,
	// cpu side
	input  logic                          cart_ce,
	input  gb_cart_pkg::cart_addr_t       cart_addr,
	input  logic                          cart_rd,
	input  logic                          cart_wr,
	input  gb_cart_pkg::byte_t            cart_di,
	output gb_cart_pkg::byte_t            cart_do,
	output logic                          cgb_game,
	// external rom
	output gb_cart_pkg::rom_waddr_t       rom_addr,
	output logic                          rom_oe,
	input  gb_cart_pkg::word_t            rom_data,
	// sd backup host
	input  logic                          load_req,
	input  logic                          save_req,
	output gb_cart_pkg::lba_t             sd_lba,
	output logic                          sd_rd,
	output logic                          sd_wr,
	input  logic                          sd_ack,
	input  logic [`SECTOR_WORDS_BITS-1:0] sd_buff_addr,
	input  gb_cart_pkg::word_t            sd_buff_dout,
	input  logic                          sd_buff_wr,
	output gb_cart_pkg::word_t            sd_buff_din,
	output logic                          busy
);
	import gb_cart_pkg::*;

	mbc_kind_t  cart_kind;
	logic       has_battery, ram_present;
	rom_bank_t  rom_mask, rom_bank;
	ram_bank_t  ram_mask, ram_bank;
	lba_t       file_mask;
	logic       mbc1_mode, rtc_mode, ram_enable;
	cram_addr_t cram_addr, bk_addr;
	logic       cram_we, bk_we;
	byte_t      cram_q;
	word_t      bk_q;

	cart_header u_header (
		.clk_sys, .reset, .dl_wr, .dl_addr, .dl_data,
		.cart_kind, .cgb_game, .has_battery, .rom_mask, .ram_mask,
		.file_mask, .ram_present
	);

	mbc_regs u_regs (
		.clk_sys, .reset, .cart_ce, .cart_wr, .cart_addr, .cart_di, .cart_kind,
		.rom_bank, .ram_bank, .mbc1_mode, .rtc_mode, .ram_enable
	);

	cart_map u_map (
		.cart_addr, .cart_rd, .cart_wr, .cart_ce, .cart_kind, .rom_bank,
		.ram_bank, .mbc1_mode, .rtc_mode, .ram_enable, .rom_mask, .ram_mask,
		.rom_data, .cram_q, .rom_addr, .rom_oe, .cram_addr, .cram_we, .cart_do
	);

	cart_ram u_ram (
		.clk_sys, .cram_addr, .cram_we, .cart_di, .cram_q,
		.bk_addr, .bk_we, .bk_din(sd_buff_dout), .bk_q
	);

	backup_ctrl u_backup (
		.clk_sys, .reset, .load_req, .save_req, .has_battery, .ram_present,
		.file_mask, .sd_ack, .sd_buff_addr, .sd_buff_wr,
		.sd_lba, .sd_rd, .sd_wr, .bk_addr, .bk_we, .busy
	);

	assign sd_buff_din = bk_q; // host samples one cycle after sd_buff_addr

endmodule

// File: test/tb_gb_cart.sv
// ------------------------------------------------
// directed testbench for the cartridge subsystem
// rom model returns its own word address, an sd
// host task serves save and load sectors
// ------------------------------------------------
`timescale 1ns/10ps
`include "gb_cart_macros.svh"

module tb_gb_cart;
	import gb_cart_pkg::*;

	localparam int RAM_BYTES    = 8192;                      // ram size code 2
	localparam int SECTOR_WORDS = 1 << `SECTOR_WORDS_BITS;
	localparam int SAVE_SECTORS = RAM_BYTES / (2 * SECTOR_WORDS); // 16 sectors
	// tests take about 30k cycles, fill + save + load + readback
	localparam int MAX_CYCLES   = 400000;

	logic                          clk_sys, reset;
	logic                          dl_wr;
	logic [24:0]                   dl_addr;
	word_t                         dl_data;
	logic                          cart_ce, cart_rd, cart_wr;
	cart_addr_t                    cart_addr;
	byte_t                         cart_di, cart_do;
	logic                          cgb_game;
	rom_waddr_t                    rom_addr;
	logic                          rom_oe;
	word_t                         rom_data;
	logic                          load_req, save_req;
	lba_t                          sd_lba;
	logic                          sd_rd, sd_wr, sd_ack, sd_buff_wr, busy;
	logic [`SECTOR_WORDS_BITS-1:0] sd_buff_addr;
	word_t                         sd_buff_dout, sd_buff_din;

	int    cycles = 0;
	int    seed_val;
	byte_t ref_ram [0:RAM_BYTES-1]; // expected cart ram contents

	gb_cart_top UUT (.*);

	assign rom_data = rom_addr[15:0]; // rom model: data is the word address

	always #50 clk_sys = ~clk_sys;

	// ------------------------------------------------
	// run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
	                           input string what);
		if (actual !== expected) begin
			$display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic tick();
		@(posedge clk_sys);
		#1; // inputs change just after the edge
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (2) tick();
		reset = 1'b0;
	endtask

	// one download strobe, header fields follow on the same edge
	task automatic download_word(input logic [24:0] addr, input word_t data);
		dl_wr   = 1'b1;
		dl_addr = addr;
		dl_data = data;
		tick();
		dl_wr   = 1'b0;
	endtask

	// header words as the download would carry them
	task automatic load_header(input byte_t kind, input byte_t ram_code, input byte_t rom_code);
		dl_wr   = 1'b1;
		dl_addr = 25'h146;
		dl_data = {kind, 8'h00};        // type in high byte
		tick();
		dl_addr = 25'h148;
		dl_data = {ram_code, rom_code};
		tick();
		dl_wr   = 1'b0;
		tick();
	endtask

	task automatic cpu_write(input logic [15:0] addr, input byte_t data);
		cart_addr = addr;
		cart_di   = data;
		cart_wr   = 1'b1;
		cart_ce   = 1'b1;
		tick();
		cart_wr   = 1'b0;
		cart_ce   = 1'b0;
	endtask

	// one cycle covers the registered ram read too
	task automatic cpu_read(input logic [15:0] addr, output byte_t data, output rom_waddr_t waddr);
		cart_addr = addr;
		cart_rd   = 1'b1;
		tick();
		data  = cart_do;
		waddr = rom_addr;
		check_value(rom_oe, addr[15:13] != 3'd5, "rom_oe");
		cart_rd   = 1'b0;
	endtask

	// 16 KB bank = 8K words
	function automatic rom_waddr_t bank_waddr(input int bank, input logic [15:0] addr);
		return rom_waddr_t'(bank) * 24'h2000 + rom_waddr_t'(addr[13:1]);
	endfunction

	// ------------------------------------------------
	// sd host side
	task automatic serve_sector(input logic expect_save, input int lba);
		word_t w;
		int    widx;
		while (!(sd_rd || sd_wr))
			tick();
		check_value(sd_wr, expect_save, "sd_wr");
		check_value(sd_rd, !expect_save, "sd_rd");
		check_value(sd_lba, lba, "sd_lba");
		sd_ack = 1'b1;
		if (expect_save) begin
			sd_buff_addr = '0;
			for (int i = 1; i <= SECTOR_WORDS; i++) begin
				tick();
				widx = lba * SECTOR_WORDS + i - 1;
				w = {ref_ram[2*widx+1], ref_ram[2*widx]}; // odd byte is the high lane
				check_value(sd_buff_din, w, "saved word");
				if (i < SECTOR_WORDS)
					sd_buff_addr = i[`SECTOR_WORDS_BITS-1:0];
			end
		end else begin
			for (int i = 0; i < SECTOR_WORDS; i++) begin
				widx = lba * SECTOR_WORDS + i;
				w = word_t'($urandom);
				ref_ram[2*widx]   = w[7:0];
				ref_ram[2*widx+1] = w[15:8];
				sd_buff_addr = i[`SECTOR_WORDS_BITS-1:0];
				sd_buff_dout = w;
				sd_buff_wr   = 1'b1;
				tick();
			end
			sd_buff_wr = 1'b0;
		end
		sd_ack = 1'b0; // falling ack closes the sector
		tick();
	endtask

	task automatic wait_idle();
		while (busy)
			tick();
		check_value(sd_rd | sd_wr, 0, "sd request after end");
	endtask

	// ------------------------------------------------
	// directed tests
	task automatic test_no_mapper();
		byte_t      d;
		rom_waddr_t wa;
		logic [15:0] exp_w;
		apply_reset();
		load_header(8'h00, 8'h00, 8'h00);
		for (int a = 0; a < 'h8000; a += 'h111) begin
			cpu_read(a[15:0], d, wa);
			exp_w = a[15:0] >> 1;          // linear 32 KB
			check_value(wa, exp_w, "rom_addr no mapper");
			check_value(d, a[0] ? exp_w[15:8] : exp_w[7:0], "cart_do no mapper");
		end
	endtask

	// 0x80 marks a cgb enhanced game, 0xc0 a cgb only game
	task automatic test_cgb_flag();
		apply_reset();
		check_value(cgb_game, 0, "cgb_game after reset");
		download_word(`HDR_CGB_WADDR, 16'h8000);
		check_value(cgb_game, 1, "cgb_game flag 0x80");
		download_word(`HDR_CGB_WADDR, 16'h0080); // flag sits in the high byte
		check_value(cgb_game, 0, "cgb_game flag in low byte");
		download_word(`HDR_CGB_WADDR, 16'hC000);
		check_value(cgb_game, 1, "cgb_game flag 0xc0");
	endtask

	task automatic test_mbc1_banks();
		byte_t      d;
		rom_waddr_t wa;
		apply_reset();
		load_header(8'h01, 8'h00, 8'h02);  // rom code 2 keeps 3 bank bits
		cpu_write(16'h2000, 8'd6);
		cpu_read(16'h5235, d, wa);
		check_value(wa, bank_waddr(6, 16'h5235), "mbc1 bank 6");
		cpu_write(16'h2000, 8'd0);         // bank 0 turns into 1
		cpu_read(16'h4000, d, wa);
		check_value(wa, bank_waddr(1, 16'h4000), "mbc1 bank 0 write");
		cpu_write(16'h2000, 8'd9);
		cpu_read(16'h4000, d, wa);
		check_value(wa, bank_waddr(9 & 'h7, 16'h4000), "mbc1 mirrored bank");
		cpu_read(16'h1234, d, wa);          // low region stays in bank 0
		check_value(wa, bank_waddr(0, 16'h1234), "mbc1 low region");
	endtask

	task automatic test_mbc5_banks();
		byte_t      d;
		rom_waddr_t wa;
		rom_waddr_t exp_wa;
		apply_reset();
		load_header(8'h19, 8'h00, 8'h08);  // rom code 8 keeps 9 bank bits
		cpu_write(16'h2000, 8'h34);
		cpu_write(16'h3000, 8'h01);        // bit 8
		cpu_read(16'h4000, d, wa);
		check_value(wa, bank_waddr('h134 & 'h1FF, 16'h4000), "mbc5 bank 0x134");
		cpu_write(16'h3000, 8'h00);
		cpu_write(16'h2000, 8'h00);
		cpu_read(16'h7FFF, d, wa);
		exp_wa = bank_waddr(0, 16'h7FFF);
		check_value(wa, exp_wa, "mbc5 bank 0");
		check_value(d, exp_wa[15:8], "mbc5 high byte");
	endtask

	task automatic test_ram_gating();
		byte_t       d;
		rom_waddr_t  wa;
		logic [15:0] addr [32];
		byte_t       val  [32];
		apply_reset();
		load_header(8'h1A, 8'h03, 8'h00);   // mbc5, 4 ram banks
		cpu_read(16'hA000, d, wa);
		check_value(d, 8'hFF, "closed ram read");
		cpu_read(16'hB123, d, wa);
		check_value(d, 8'hFF, "closed ram read");
		cpu_write(16'h0000, 8'h0A);
		for (int i = 0; i < 32; i++) begin
			if (i % 8 == 0)
				cpu_write(16'h4000, byte_t'(i / 8)); // next ram bank
			addr[i] = 16'hA000 + (((i % 8) * 'h3A7 + (i / 8) * 'h55) & 'h1FFF);
			val[i]  = byte_t'($urandom);
			cpu_write(addr[i], val[i]);
		end
		for (int i = 0; i < 32; i++) begin
			cpu_write(16'h4000, byte_t'(i / 8));
			cpu_read(addr[i], d, wa);
			check_value(d, val[i], "banked ram readback");
		end
		cpu_write(16'h0000, 8'h00);
		cpu_read(addr[0], d, wa);
		check_value(d, 8'hFF, "ram closed again");

		// mbc2, only the low nibble exists
		apply_reset();
		load_header(8'h06, 8'h00, 8'h00);
		cpu_write(16'h0000, 8'h0A);
		for (int i = 0; i < 4; i++) begin
			val[i] = byte_t'($urandom);
			cpu_write(16'hA010 + i * 'h61, val[i]);
			cpu_read(16'hA010 + i * 'h61, d, wa);
			check_value(d, {4'hF, val[i][3:0]}, "mbc2 nibble read");
		end
	endtask

	task automatic test_save();
		apply_reset();
		load_header(8'h03, 8'h02, 8'h00);   // mbc1 + ram + battery, 8 KB
		cpu_write(16'h0000, 8'h0A);
		for (int i = 0; i < RAM_BYTES; i++) begin
			ref_ram[i] = byte_t'($urandom);
			cpu_write(16'hA000 + i, ref_ram[i]);
		end
		save_req = 1'b1;
		tick();
		save_req = 1'b0;
		check_value(busy, 1, "busy after save request");
		for (int s = 0; s < SAVE_SECTORS; s++)
			serve_sector(1'b1, s);
		wait_idle();
	endtask

	task automatic test_load();
		byte_t      d;
		rom_waddr_t wa;
		apply_reset();
		load_header(8'h03, 8'h02, 8'h00);
		load_req = 1'b1;
		tick();
		load_req = 1'b0;
		check_value(busy, 1, "busy after load request");
		for (int s = 0; s < SAVE_SECTORS; s++)
			serve_sector(1'b0, s);
		wait_idle();
		cpu_write(16'h0000, 8'h0A);
		for (int i = 0; i < RAM_BYTES; i++) begin
			cpu_read(16'hA000 + i, d, wa);
			check_value(d, ref_ram[i], "loaded byte");
		end
	endtask

	task automatic test_no_battery();
		apply_reset();
		load_header(8'h01, 8'h02, 8'h00);   // mbc1 without battery
		save_req = 1'b1;
		tick();
		save_req = 1'b0;
		repeat (20) begin
			tick();
			check_value(busy, 0, "busy without battery");
			check_value(sd_wr, 0, "sd_wr without battery");
		end
	endtask

	initial begin
		clk_sys      = 1'b0;
		reset        = 1'b1;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		cart_ce      = 1'b0;
		cart_rd      = 1'b0;
		cart_wr      = 1'b0;
		cart_addr    = '0;
		cart_di      = '0;
		load_req     = 1'b0;
		save_req     = 1'b0;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		seed_val     = 52;
		seed_val     = $urandom(seed_val); // seeds the generator once

		test_no_mapper();
		test_cgb_flag();
		test_mbc1_banks();
		test_mbc5_banks();
		test_ram_gating();
		test_save();
		test_load();
		test_no_battery();

		$display("TEST PASS");
		$finish;
	end

endmodule

// File: list.f
+incdir+src
src/gb_cart_pkg.sv
src/cart_header.sv
src/mbc_regs.sv
src/cart_map.sv
src/cart_ram.sv
src/backup_ctrl.sv
src/gb_cart_top.sv
test/tb_gb_cart.sv

// File: Bender.yml
package:
  name: gb_cart

export_include_dirs:
  - src

sources:
  - files:
      - src/gb_cart_pkg.sv
      - src/cart_header.sv
      - src/mbc_regs.sv
      - src/cart_map.sv
      - src/cart_ram.sv
      - src/backup_ctrl.sv
      - src/gb_cart_top.sv
  - target: simulation
    files:
      - test/tb_gb_cart.sv
